// ==== list.f ====
+incdir+bench
design/edge_cfg_pkg.sv
design/edge_types_pkg.sv
design/write_heap_ctrl.sv
design/write_beat_tracker.sv
design/write_header_canon.sv
design/write_data_heap.sv
design/afu_write_edge.sv
bench/edge_tb.sv

// ==== bench/edge_tb_model.svh ====
// ====================
// Write edge testbench model
// Random source, reference packet model and the queue of packets
// that are expected to come back as control flits
// ====================

`ifndef EDGE_TB_MODEL_SVH
`define EDGE_TB_MODEL_SVH

timeunit 1ns;
timeprecision 1ps;

// Packets sent whose flit has not been seen yet, oldest first
edge_types_pkg::t_line_addr exp_addr [$];
edge_types_pkg::t_cl_len    exp_len [$];
edge_types_pkg::t_line_data exp_data [$];

// Beats of the packet being sent, as they were driven on the bus
edge_types_pkg::t_line_addr beat_log_addr [edge_cfg_pkg::MAX_BEATS];
edge_types_pkg::t_line_data beat_log_data [edge_cfg_pkg::MAX_BEATS];

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
function automatic logic lfsr_step(inout logic [15:0] state);
    logic fb;
    fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
    state = {state[14:0], fb};
    return fb;
endfunction

// One LFSR step for every bit taken
function automatic logic [63:0] rand_bits(inout logic [15:0] state, input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
        val = {val[62:0], lfsr_step(state)};
    end
    return val;
endfunction

// The flit carries the start beat's address and a length code of beat
// count minus one, whatever the later beats put on the bus
function automatic void model_packet(input int n_beats);
    exp_addr.push_back(beat_log_addr[0]);
    exp_len.push_back(edge_types_pkg::t_cl_len'(n_beats - 1));
    for (int b = 0; b < n_beats; b++)
    begin
        exp_data.push_back(beat_log_data[b]);
    end
endfunction

// Oldest expected flit, or 0 when nothing is expected
function automatic logic next_expected(output edge_types_pkg::t_line_addr addr,
                                       output edge_types_pkg::t_cl_len len,
                                       output int n_beats);
    addr    = '0;
    len     = '0;
    n_beats = 0;
    if (exp_addr.size() == 0)
    begin
        return 1'b0;
    end
    addr    = exp_addr.pop_front();
    len     = exp_len.pop_front();
    n_beats = int'(len) + 1;
    return 1'b1;
endfunction

`endif

// ==== bench/edge_tb.sv ====
// ====================
// Write edge testbench
// Sends random write packets with garbage on the non-start beats,
// checks each control flit and the parked data, frees heap entries
// and drives both causes of almost_full
// ====================

module edge_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "edge_tb_model.svh"

    localparam int N_HEAP_ENTRIES   = 16;
    localparam int IDX_W            = $clog2(N_HEAP_ENTRIES);
    localparam int N_RANDOM_PKTS    = 60;
    localparam int WAIT_LIMIT       = 200;
    localparam int DRAIN_LIMIT      = 2000;
    localparam int DRAIN_IDLE_LIMIT = 5000;

    logic                       clk;
    logic                       reset;
    logic                       wr_valid;
    logic                       wr_sop;
    edge_types_pkg::t_cl_len    wr_cl_len;
    edge_types_pkg::t_line_addr wr_addr;
    edge_types_pkg::t_line_data wr_data;
    logic                       almost_full;
    logic                       req_valid;
    edge_types_pkg::t_line_addr req_addr;
    edge_types_pkg::t_cl_len    req_cl_len;
    logic [IDX_W-1:0]           req_heap_idx;
    logic                       fiu_almost_full;
    logic                       free;
    logic [IDX_W-1:0]           free_idx;
    logic [IDX_W-1:0]           rd_idx;
    edge_types_pkg::t_cl_num    rd_cl_num;
    edge_types_pkg::t_line_data rd_data;

    // Flits seen but not yet read back and freed
    logic [IDX_W-1:0]           pend_idx [$];
    int                         pend_beats [$];
    edge_types_pkg::t_line_data pend_data [$];
    logic                       outstanding [N_HEAP_ENTRIES];

    int          mismatch_count;
    int          fail_count;
    int          timeout_count;
    int          sent_count;
    int          flit_count;
    int          freed_count;
    logic        hold_free;
    logic [15:0] stim_lfsr;
    logic [15:0] drain_lfsr;
    event        abort_run;

    afu_write_edge #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .wr_valid        (wr_valid),
        .wr_sop          (wr_sop),
        .wr_cl_len       (wr_cl_len),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .almost_full     (almost_full),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_cl_len      (req_cl_len),
        .req_heap_idx    (req_heap_idx),
        .fiu_almost_full (fiu_almost_full),
        .free            (free),
        .free_idx        (free_idx),
        .rd_idx          (rd_idx),
        .rd_cl_num       (rd_cl_num),
        .rd_data         (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // ====================
    // Checking and reporting
    // ====================

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t: %s", $time, what);
        -> abort_run;
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatch_count, fail_count, timeout_count);
        if (mismatch_count == 0 && fail_count == 0 && timeout_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // A timed-out wait ends the run from here
    initial
    begin
        @(abort_run);
        finish_run();
    end

    // ====================
    // Stimulus helpers
    // ====================

    // Length codes 0, 1 and 3 only
    function automatic edge_types_pkg::t_cl_len pick_len();
        logic [1:0] r;
        r = 2'(rand_bits(stim_lfsr, 2));
        return (r == 2'd2) ? 2'd3 : r;
    endfunction

    // Called on a falling edge, returns on the falling edge after the last beat
    task automatic send_packet(input edge_types_pkg::t_cl_len len);
        edge_types_pkg::t_line_addr addr;
        int                         n_beats;
        n_beats = int'(len) + 1;
        addr    = edge_types_pkg::t_line_addr'(rand_bits(stim_lfsr, 16));
        addr    = addr & ~edge_types_pkg::t_line_addr'(len);
        for (int b = 0; b < n_beats; b++)
        begin
            beat_log_addr[b] = (b == 0) ? addr :
                               edge_types_pkg::t_line_addr'(rand_bits(stim_lfsr, 16));
            beat_log_data[b] = rand_bits(stim_lfsr, 64);
            wr_valid  = 1'b1;
            wr_sop    = (b == 0);
            wr_addr   = beat_log_addr[b];
            // Later beats carry a random length code that the DUT must ignore
            wr_cl_len = (b == 0) ? len : edge_types_pkg::t_cl_len'(rand_bits(stim_lfsr, 2));
            wr_data   = beat_log_data[b];
            if (b == n_beats - 1)
            begin
                model_packet(n_beats);
            end
            @(negedge clk);
        end
        wr_valid = 1'b0;
        wr_sop   = 1'b0;
        sent_count++;
    endtask

    task automatic wait_room(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b1;
        while (ok && almost_full)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                report_timeout("almost_full stayed high with entries being freed");
                ok = 1'b0;
            end
            else
            begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_all_freed(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b1;
        while (ok && (freed_count != sent_count))
        begin
            if (cycles == DRAIN_LIMIT)
            begin
                report_timeout("sent packets were never all delivered and freed");
                ok = 1'b0;
            end
            else
            begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        logic ok;
        int   gap;
        int   pkts;
        $timeformat(-9, 0, " ns", 0);
        mismatch_count  = 0;
        fail_count      = 0;
        timeout_count   = 0;
        sent_count      = 0;
        hold_free       = 1'b0;
        stim_lfsr       = 16'd18;
        reset           = 1'b1;
        wr_valid        = 1'b0;
        wr_sop          = 1'b0;
        wr_cl_len       = '0;
        wr_addr         = '0;
        wr_data         = '0;
        fiu_almost_full = 1'b0;
        ok              = 1'b1;

        // Outputs are checked after each reset edge, the last one included
        for (int i = 0; i < 16; i++)
        begin
            @(negedge clk);
            check_value("almost_full during reset", almost_full, 1'b1);
            check_value("req_valid during reset", req_valid, 1'b0);
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("req_valid after reset", req_valid, 1'b0);
        check_value("almost_full with an empty heap", almost_full, 1'b0);

        // Downstream almost-full shows up one cycle later
        fiu_almost_full = 1'b1;
        @(negedge clk);
        check_value("almost_full from downstream", almost_full, 1'b1);
        fiu_almost_full = 1'b0;
        @(negedge clk);
        check_value("almost_full after downstream release", almost_full, 1'b0);

        // Random traffic with the drain freeing entries
        for (int p = 0; p < N_RANDOM_PKTS && ok; p++)
        begin
            gap = int'(rand_bits(stim_lfsr, 2));
            repeat (gap) @(negedge clk);
            wait_room(ok);
            if (ok)
            begin
                send_packet(pick_len());
            end
        end
        if (ok)
        begin
            wait_all_freed(ok);
        end

        // Stop freeing and send back to back until almost_full rises
        if (ok)
        begin
            hold_free = 1'b1;
            pkts      = 0;
            while (ok && !almost_full)
            begin
                if (pkts == 2 * N_HEAP_ENTRIES)
                begin
                    report_timeout("almost_full never rose with frees held");
                    ok = 1'b0;
                end
                else
                begin
                    send_packet(pick_len());
                    pkts++;
                end
            end
        end
        if (ok)
        begin
            repeat (4)
            begin
                @(negedge clk);
                check_value("almost_full with frees held", almost_full, 1'b1);
            end
            hold_free = 1'b0;
            wait_all_freed(ok);
        end

        if (ok)
        begin
            repeat (2) @(negedge clk);
            check_value("almost_full after the heap drained", almost_full, 1'b0);
            check_value("flit count", flit_count, sent_count);
            finish_run();
        end
    end

    // ====================
    // Flit compare process
    // ====================

    initial
    begin
        edge_types_pkg::t_line_addr e_addr;
        edge_types_pkg::t_cl_len    e_len;
        int                         n_beats;
        logic                       have;
        flit_count = 0;
        for (int i = 0; i < N_HEAP_ENTRIES; i++)
        begin
            outstanding[i] = 1'b0;
        end
        forever
        begin
            @(negedge clk);
            if (req_valid === 1'b1)
            begin
                flit_count++;
                have = next_expected(e_addr, e_len, n_beats);
                assert (have)
                else
                begin
                    fail_count++;
                    $display("Flit at %0t arrived with no packet left to match", $time);
                end
                if (have)
                begin
                    check_value("flit address", req_addr, e_addr);
                    check_value("flit length code", req_cl_len, e_len);
                    assert (!outstanding[req_heap_idx])
                    else
                    begin
                        fail_count++;
                        $display("Heap index %0d at %0t is already held by another packet",
                                 req_heap_idx, $time);
                    end
                    outstanding[req_heap_idx] = 1'b1;
                    pend_idx.push_back(req_heap_idx);
                    pend_beats.push_back(n_beats);
                    for (int b = 0; b < n_beats; b++)
                    begin
                        pend_data.push_back(exp_data.pop_front());
                    end
                end
            end
        end
    end

    // Reads back every beat of a delivered packet, then frees its entry
    initial
    begin
        logic [IDX_W-1:0] idx;
        int               n_beats;
        int               delay;
        int               idle;
        free        = 1'b0;
        free_idx    = '0;
        rd_idx      = '0;
        rd_cl_num   = '0;
        freed_count = 0;
        drain_lfsr  = 16'd18;
        forever
        begin
            idle = 0;
            while (pend_idx.size() == 0)
            begin
                if (idle == DRAIN_IDLE_LIMIT)
                begin
                    report_timeout("no flit arrived for the drain to service");
                end
                idle++;
                @(negedge clk);
            end
            idx     = pend_idx.pop_front();
            n_beats = pend_beats.pop_front();
            delay   = int'(rand_bits(drain_lfsr, 3));
            repeat (delay) @(negedge clk);

            // Read data is registered, so it is checked one cycle later
            for (int b = 0; b < n_beats; b++)
            begin
                rd_idx    = idx;
                rd_cl_num = edge_types_pkg::t_cl_num'(b);
                @(negedge clk);
                check_value("heap read data", rd_data, pend_data.pop_front());
            end

            idle = 0;
            while (hold_free)
            begin
                if (idle == DRAIN_IDLE_LIMIT)
                begin
                    report_timeout("frees stayed held");
                end
                idle++;
                @(negedge clk);
            end
            free             = 1'b1;
            free_idx         = idx;
            outstanding[idx] = 1'b0;
            freed_count++;
            @(negedge clk);
            free = 1'b0;
        end
    end

endmodule

// ==== design/afu_write_edge.sv ====
// ====================
// Accelerator write edge
// Parks write beats in a local heap, sends one control flit per packet
// downstream and drives a registered almost_full to the accelerator
// ====================

module afu_write_edge
#(
    parameter int N_HEAP_ENTRIES = 16
)
(
    input  logic                              clk,
    input  logic                              reset,

    // Write beats from the accelerator
    input  logic                              wr_valid,
    input  logic                              wr_sop,
    input  edge_types_pkg::t_cl_len           wr_cl_len,
    input  edge_types_pkg::t_line_addr        wr_addr,
    input  edge_types_pkg::t_line_data        wr_data,
    output logic                              almost_full,

    // Control flits toward the downstream pipeline
    output logic                              req_valid,
    output edge_types_pkg::t_line_addr        req_addr,
    output edge_types_pkg::t_cl_len           req_cl_len,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] req_heap_idx,
    input  logic                              fiu_almost_full,

    // Downstream heap release and read port
    input  logic                              free,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] free_idx,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] rd_idx,
    input  edge_types_pkg::t_cl_num           rd_cl_num,
    output edge_types_pkg::t_line_data        rd_data
);

    typedef logic [$clog2(N_HEAP_ENTRIES)-1:0] t_heap_idx;

    t_heap_idx               alloc_idx;
    logic                    alloc;
    logic                    not_full;
    edge_types_pkg::t_cl_num beat_num;
    logic                    last_beat;

    // ====================
    // Heap allocation
    // ====================

    // An entry is consumed only when its packet's last beat is stored
    assign alloc = wr_valid && last_beat;

    write_heap_ctrl #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) u_heap_ctrl (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .alloc_idx (alloc_idx),
        .not_full  (not_full),
        .free      (free),
        .free_idx  (free_idx)
    );

    write_beat_tracker u_beat_tracker (
        .clk         (clk),
        .reset       (reset),
        .beat_valid  (wr_valid),
        .beat_sop    (wr_sop),
        .beat_cl_len (wr_cl_len),
        .beat_addr   (wr_addr),
        .beat_num    (beat_num),
        .last_beat   (last_beat)
    );

    // ====================
    // Flit and data paths
    // ====================

    write_header_canon #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) u_header_canon (
        .clk          (clk),
        .reset        (reset),
        .beat_valid   (wr_valid),
        .beat_sop     (wr_sop),
        .beat_cl_len  (wr_cl_len),
        .beat_addr    (wr_addr),
        .beat_num     (beat_num),
        .last_beat    (last_beat),
        .alloc_idx    (alloc_idx),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_cl_len   (req_cl_len),
        .req_heap_idx (req_heap_idx)
    );

    // Every beat lands in the entry the packet will own
    write_data_heap #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) u_data_heap (
        .clk       (clk),
        .wen       (wr_valid),
        .widx      (alloc_idx),
        .wcl_num   (beat_num),
        .wdata     (wr_data),
        .rd_idx    (rd_idx),
        .rd_cl_num (rd_cl_num),
        .rd_data   (rd_data)
    );

    // Registered almost_full, one cycle behind its causes and held
    // high through reset so the accelerator waits for the free list
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            almost_full <= 1'b1;
        end
        else
        begin
            almost_full <= fiu_almost_full || !not_full;
        end
    end

endmodule

// ==== design/write_data_heap.sv ====
// ====================
// Write data heap
// Line storage for parked write beats, addressed by heap entry and
// beat number, with a one-cycle registered read port
// ====================

module write_data_heap
#(
    parameter int N_HEAP_ENTRIES = 16
)
(
    input  logic                              clk,
    input  logic                              wen,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] widx,
    input  edge_types_pkg::t_cl_num           wcl_num,
    input  edge_types_pkg::t_line_data        wdata,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] rd_idx,
    input  edge_types_pkg::t_cl_num           rd_cl_num,
    output edge_types_pkg::t_line_data        rd_data
);

    // Each entry owns one slot per possible beat
    localparam int DEPTH  = N_HEAP_ENTRIES * edge_cfg_pkg::MAX_BEATS;
    localparam int ADDR_W = $clog2(DEPTH);

    typedef logic [ADDR_W-1:0] t_heap_addr;

    edge_types_pkg::t_line_data mem [DEPTH];

    t_heap_addr waddr;
    t_heap_addr raddr;

    // Entry index in the upper bits, beat number in the lower bits
    assign waddr = {widx, wcl_num};
    assign raddr = {rd_idx, rd_cl_num};

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
        rd_data <= mem[raddr];
    end

endmodule

// ==== design/write_header_canon.sv ====
// ====================
// Write header canonicalizer
// Restores the start-beat address and length on the later beats of
// a packet and issues one control flit when the last beat is stored
// ====================

module write_header_canon
#(
    parameter int N_HEAP_ENTRIES = 16
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              beat_valid,
    input  logic                              beat_sop,
    input  edge_types_pkg::t_cl_len           beat_cl_len,
    input  edge_types_pkg::t_line_addr        beat_addr,
    input  edge_types_pkg::t_cl_num           beat_num,
    input  logic                              last_beat,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] alloc_idx,
    output logic                              req_valid,
    output edge_types_pkg::t_line_addr        req_addr,
    output edge_types_pkg::t_cl_len           req_cl_len,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] req_heap_idx
);

    // Header fields captured from the start beat
    edge_types_pkg::t_line_addr saved_addr;
    edge_types_pkg::t_cl_len    saved_len;

    // Canonical header of the current beat
    edge_types_pkg::t_line_addr canon_addr;
    edge_types_pkg::t_cl_len    canon_len;

    always_ff @(posedge clk)
    begin
        if (beat_valid && beat_sop)
        begin
            saved_addr <= beat_addr;
            saved_len  <= beat_cl_len;
        end
    end

    // Address and length of non-start beats are don't-care on the bus
    always_comb
    begin
        canon_addr = beat_addr;
        canon_len  = beat_cl_len;
        if (!beat_sop)
        begin
            canon_addr = saved_addr;
            canon_len  = saved_len;
        end
    end

    // Only the last beat launches a flit, so the whole packet is in the heap
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_valid <= 1'b0;
        end
        else
        begin
            req_valid <= beat_valid && last_beat;
        end
    end

    // Flit payload holds until the next packet completes
    always_ff @(posedge clk)
    begin
        if (beat_valid && last_beat)
        begin
            req_addr     <= canon_addr;
            req_cl_len   <= canon_len;
            req_heap_idx <= alloc_idx;
        end
    end

    // The header is only captured from a beat that opens its packet
    assert property (@(posedge clk) disable iff (reset)
        (beat_valid && beat_sop) |-> (beat_num == '0))
        else $error("write_header_canon: start beat with a nonzero beat number");

endmodule

// ==== design/write_beat_tracker.sv ====
// ====================
// Write beat tracker
// Numbers the beats of a multi-beat write, flags the final beat and
// checks that the accelerator formats packets correctly
// ====================

module write_beat_tracker
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       beat_valid,
    input  logic                       beat_sop,
    input  edge_types_pkg::t_cl_len    beat_cl_len,
    input  edge_types_pkg::t_line_addr beat_addr,
    output edge_types_pkg::t_cl_num    beat_num,
    output logic                       last_beat
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } t_state;

    t_state                  state;
    edge_types_pkg::t_cl_len saved_len;
    edge_types_pkg::t_cl_len cur_len;

    // A start beat carries its own length, later beats use the saved one
    assign cur_len   = beat_sop ? beat_cl_len : saved_len;
    assign last_beat = (beat_num == cur_len);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_IDLE;
            beat_num <= '0;
        end
        else if (beat_valid)
        begin
            if (last_beat)
            begin
                state    <= ST_IDLE;
                beat_num <= '0;
            end
            else
            begin
                state    <= ST_ACTIVE;
                beat_num <= beat_num + 1'b1;
            end
        end
    end

    // Length of the packet in progress
    always_ff @(posedge clk)
    begin
        if (beat_valid && beat_sop)
        begin
            saved_len <= beat_cl_len;
        end
    end

    // A start flag opens a packet, and every other beat continues one
    assert property (@(posedge clk) disable iff (reset)
        beat_valid |-> (beat_sop == (state == ST_IDLE)))
        else $error("write_beat_tracker: start flag does not match packet state");

    assert property (@(posedge clk) disable iff (reset)
        (beat_valid && beat_sop) |-> ((beat_addr[1:0] & beat_cl_len) == '0))
        else $error("write_beat_tracker: multi-beat address not naturally aligned");

    assert property (@(posedge clk) disable iff (reset)
        (beat_valid && beat_sop) |-> (beat_cl_len != 2'd2))
        else $error("write_beat_tracker: illegal length code on start beat");

endmodule

// ==== design/write_heap_ctrl.sv ====
// ====================
// Write heap allocator
// Hands out heap entries from a circular free list and takes them
// back when the downstream side frees them. not_full drops while the
// free count is inside the reserve needed to absorb late beats
// ====================

module write_heap_ctrl
#(
    parameter int N_HEAP_ENTRIES = 16
)
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              alloc,
    output logic [$clog2(N_HEAP_ENTRIES)-1:0] alloc_idx,
    output logic                              not_full,
    input  logic                              free,
    input  logic [$clog2(N_HEAP_ENTRIES)-1:0] free_idx
);

    localparam int IDX_W = $clog2(N_HEAP_ENTRIES);

    // Room for the beats allowed after almost_full plus one whole packet,
    // since almost_full is never honoured in the middle of a packet
    localparam int RESERVE = edge_cfg_pkg::ALMOST_FULL_THRESHOLD +
                             edge_cfg_pkg::MAX_BEATS + 1;

    typedef logic [IDX_W-1:0] t_heap_idx;
    typedef logic [IDX_W:0]   t_heap_cnt;

    // Free list storage and its pointers
    t_heap_idx free_list [N_HEAP_ENTRIES];
    t_heap_idx head;
    t_heap_idx tail;
    t_heap_cnt free_cnt;

    // The head entry is the one the packet in flight is filling
    assign alloc_idx = free_list[head];
    assign not_full  = (free_cnt > t_heap_cnt'(RESERVE));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every entry starts out free
            for (int i = 0; i < N_HEAP_ENTRIES; i++)
            begin
                free_list[i] <= t_heap_idx'(i);
            end
            head     <= '0;
            tail     <= '0;
            free_cnt <= t_heap_cnt'(N_HEAP_ENTRIES);
        end
        else
        begin
            if (alloc)
            begin
                head <= head + 1'b1;
            end

            // A freed index is pushed at the tail and may be popped next cycle
            if (free)
            begin
                free_list[tail] <= free_idx;
                tail            <= tail + 1'b1;
            end

            case ({alloc, free})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // Upstream flow control must keep the allocator from running dry
    assert property (@(posedge clk) disable iff (reset)
        alloc |-> (free_cnt != '0))
        else $error("write_heap_ctrl: allocation from an empty free list");

    // Downstream must free each entry exactly once
    assert property (@(posedge clk) disable iff (reset)
        free |-> (free_cnt != t_heap_cnt'(N_HEAP_ENTRIES)))
        else $error("write_heap_ctrl: free with every entry already free");

endmodule

// ==== design/edge_types_pkg.sv ====
// ====================
// Write edge types
// Vector types for the fields that travel with a write beat
// ====================

package edge_types_pkg;

    // Line address as presented by the accelerator
    typedef logic [edge_cfg_pkg::ADDR_W-1:0] t_line_addr;

    // Length code is beat count minus one, so 0, 1 and 3 are legal
    typedef logic [$clog2(edge_cfg_pkg::MAX_BEATS)-1:0] t_cl_len;

    // Position of a beat inside its packet
    typedef logic [$clog2(edge_cfg_pkg::MAX_BEATS)-1:0] t_cl_num;

    // One line of write data
    typedef logic [edge_cfg_pkg::DATA_W-1:0] t_line_data;

endpackage

// ==== design/edge_cfg_pkg.sv ====
// ====================
// Write edge configuration
// Numeric limits of the write path: packet size, the flow-control
// threshold honoured by the accelerator, and the bus widths
// ====================

package edge_cfg_pkg;

    // Largest multi-beat write packet, in beats
    localparam int MAX_BEATS = 4;

    // Beats the accelerator may still send after it sees almost_full.
    // The heap reserve is sized from this value
    localparam int ALMOST_FULL_THRESHOLD = 4;

    // Line address width
    localparam int ADDR_W = 16;

    // Width of one data line
    localparam int DATA_W = 64;

endpackage
